/* hdl/hwpf_stride.sv */
`timescale 1ns/1ps
// Single-stream stride prefetcher fed by the accepted load addresses.
// At most one prefetch in flight; snoops during that time only retrain.
// Strides are taken modulo 2^32, so a descending stream also trains.
// Prefetch response data is dropped; only its arrival is tracked.
module hwpf_stride import l1_mem_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        enable_i,
  // Load snoop
  input  logic        snoop_valid_i,
  input  paddr_t      snoop_addr_i,
  // Arbiter side
  output logic        arb_req_valid_o,
  output mem_req_t    arb_req_o,
  input  logic        arb_gnt_i,
  input  logic        arb_rsp_valid_i,
  output logic [15:0] issued_count_o
);

  hwpf_state_e state_q, state_d;
  paddr_t      last_addr_q;   // Previous snooped address
  paddr_t      stride_q;      // Previous stride
  paddr_t      pf_addr_q;     // Address being prefetched
  paddr_t      snoop_delta;
  logic        snoop_hit;
  logic        stride_match;
  logic        arm;
  logic [15:0] count_q;

  assign snoop_hit    = snoop_valid_i & enable_i;
  assign snoop_delta  = snoop_addr_i - last_addr_q;
  assign stride_match = (snoop_delta != '0) && (snoop_delta == stride_q);
  assign arm          = (state_q == TRAIN) & snoop_hit & stride_match;

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (snoop_hit) begin
          state_d = TRAIN;
        end
      end
      TRAIN: begin
        if (!enable_i) begin
          state_d = IDLE;
        end else if (arm) begin
          state_d = ARMED;
        end
      end
      ARMED: begin
        if (arb_gnt_i) begin
          state_d = ISSUE;
        end
      end
      ISSUE: begin
        // Back to training once the line has come back
        if (arb_rsp_valid_i) begin
          state_d = enable_i ? TRAIN : IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      count_q <= '0;
    end else begin
      state_q <= state_d;
      if (arb_gnt_i) begin
        count_q <= count_q + 16'd1;
      end
    end
  end

  // Training history, updated by every snoop even with a prefetch in flight
  always_ff @(posedge clk_i) begin
    if (snoop_hit) begin
      last_addr_q <= snoop_addr_i;
      stride_q    <= (state_q == IDLE) ? '0 : snoop_delta;
    end
    if (arm) begin
      pf_addr_q <= snoop_addr_i + snoop_delta;  // One stride ahead
    end
  end

  assign arb_req_valid_o = (state_q == ARMED);
  assign arb_req_o       = '{id: REQ_ID_HWPF, addr: pf_addr_q};
  assign issued_count_o  = count_q;

  // Once granted, no new prefetch may be requested until the response returns
  a_single_outstanding: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    arb_gnt_i |=> (!arb_req_valid_o until arb_rsp_valid_i)
  ) else $error("hwpf_stride: prefetch raised while another is outstanding");

endmodule : hwpf_stride

/* hdl/l1_mem_pkg.sv */
// Shared types for the L1 miss path toward memory.
// Addresses are physical byte addresses; every request returns one 64-bit word.
// Requester IDs are fixed per peer; ID 3 is never issued on the bus.
package l1_mem_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths with a meaning
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] paddr_t;   // Physical byte address
  typedef logic [63:0] word_t;    // Returned data word
  typedef logic [1:0]  mem_id_t;  // Requester ID on the memory bus

  // Requester IDs, also the arbiter channel index
  localparam mem_id_t REQ_ID_FETCH = 2'd0;
  localparam mem_id_t REQ_ID_LOAD  = 2'd1;
  localparam mem_id_t REQ_ID_HWPF  = 2'd2;

  localparam int unsigned NUM_REQUESTERS = 3;

  //////////////////////////////////////////////////////////////////////
  // Bus payloads
  //////////////////////////////////////////////////////////////////////

  // Request toward memory, 34 bits
  typedef struct packed {
    mem_id_t id;
    paddr_t  addr;
  } mem_req_t;

  // Response from memory, 66 bits
  typedef struct packed {
    mem_id_t id;
    word_t   data;
  } mem_rsp_t;

  //////////////////////////////////////////////////////////////////////
  // Prefetcher FSM
  //////////////////////////////////////////////////////////////////////

  // IDLE   nothing snooped yet, or disabled
  // TRAIN  last address known, stride being learned
  // ARMED  stride confirmed, prefetch request waiting for grant
  // ISSUE  prefetch granted, waiting for its response
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    TRAIN = 2'd1,
    ARMED = 2'd2,
    ISSUE = 2'd3
  } hwpf_state_e;

endpackage : l1_mem_pkg

/* hdl/l1_miss_subsystem.sv */
`timescale 1ns/1ps
// Memory-side miss path: fetch and load miss ports plus one stride prefetcher
// share a credit-limited request/response bus through a round-robin arbiter.
// Each port has one miss in flight; responses come back in any order by ID.
// MemCredits must match the number of slots the memory can hold (1 to 15).
module l1_miss_subsystem import l1_mem_pkg::*; #(
  parameter int unsigned MemCredits = 4
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  // Instruction fetch misses
  input  logic        fetch_req_valid_i,
  input  paddr_t      fetch_req_addr_i,
  output logic        fetch_req_ready_o,
  output logic        fetch_rsp_valid_o,
  output word_t       fetch_rsp_data_o,
  // Data load misses
  input  logic        load_req_valid_i,
  input  paddr_t      load_req_addr_i,
  output logic        load_req_ready_o,
  output logic        load_rsp_valid_o,
  output word_t       load_rsp_data_o,
  // Prefetcher control and status
  input  logic        hwpf_enable_i,
  output logic [15:0] hwpf_issued_o,
  // Memory bus
  output logic        mem_req_valid_o,
  output mem_req_t    mem_req_o,
  input  logic        mem_rsp_valid_i,
  input  mem_rsp_t    mem_rsp_i,
  input  logic        mem_credit_i
);

  // Arbiter channels, one slot per requester ID
  logic     [NUM_REQUESTERS-1:0] arb_req_valid;
  mem_req_t [NUM_REQUESTERS-1:0] arb_req;
  logic     [NUM_REQUESTERS-1:0] arb_gnt;
  logic     [NUM_REQUESTERS-1:0] arb_rsp_valid;
  mem_rsp_t                      arb_rsp;

  logic   load_snoop_valid;
  paddr_t load_snoop_addr;

  //////////////////////////////////////////////////////////////////////
  // Requesters
  //////////////////////////////////////////////////////////////////////

  miss_port #(
    .PortId           (REQ_ID_FETCH)
  ) i_fetch_port (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .core_req_valid_i (fetch_req_valid_i),
    .core_req_addr_i  (fetch_req_addr_i),
    .core_req_ready_o (fetch_req_ready_o),
    .core_rsp_valid_o (fetch_rsp_valid_o),
    .core_rsp_data_o  (fetch_rsp_data_o),
    .arb_req_valid_o  (arb_req_valid[REQ_ID_FETCH]),
    .arb_req_o        (arb_req[REQ_ID_FETCH]),
    .arb_gnt_i        (arb_gnt[REQ_ID_FETCH]),
    .arb_rsp_valid_i  (arb_rsp_valid[REQ_ID_FETCH]),
    .arb_rsp_i        (arb_rsp),
    .snoop_valid_o    (),                // Fetches do not train the prefetcher
    .snoop_addr_o     ()
  );

  miss_port #(
    .PortId           (REQ_ID_LOAD)
  ) i_load_port (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .core_req_valid_i (load_req_valid_i),
    .core_req_addr_i  (load_req_addr_i),
    .core_req_ready_o (load_req_ready_o),
    .core_rsp_valid_o (load_rsp_valid_o),
    .core_rsp_data_o  (load_rsp_data_o),
    .arb_req_valid_o  (arb_req_valid[REQ_ID_LOAD]),
    .arb_req_o        (arb_req[REQ_ID_LOAD]),
    .arb_gnt_i        (arb_gnt[REQ_ID_LOAD]),
    .arb_rsp_valid_i  (arb_rsp_valid[REQ_ID_LOAD]),
    .arb_rsp_i        (arb_rsp),
    .snoop_valid_o    (load_snoop_valid),
    .snoop_addr_o     (load_snoop_addr)
  );

  hwpf_stride i_hwpf (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .enable_i        (hwpf_enable_i),
    .snoop_valid_i   (load_snoop_valid),
    .snoop_addr_i    (load_snoop_addr),
    .arb_req_valid_o (arb_req_valid[REQ_ID_HWPF]),
    .arb_req_o       (arb_req[REQ_ID_HWPF]),
    .arb_gnt_i       (arb_gnt[REQ_ID_HWPF]),
    .arb_rsp_valid_i (arb_rsp_valid[REQ_ID_HWPF]),
    .issued_count_o  (hwpf_issued_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Shared bus
  //////////////////////////////////////////////////////////////////////

  mem_arbiter #(
    .MemCredits      (MemCredits)
  ) i_arbiter (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (arb_req_valid),
    .req_i           (arb_req),
    .gnt_o           (arb_gnt),
    .rsp_valid_o     (arb_rsp_valid),
    .rsp_o           (arb_rsp),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .credit_i        (mem_credit_i),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_i       (mem_rsp_i)
  );

endmodule : l1_miss_subsystem

/* hdl/mem_arbiter.sv */
`timescale 1ns/1ps
// Round-robin arbiter onto one memory bus, one request per cycle at most.
// MemCredits must be 1 to 15; the memory returns one credit per freed slot.
// Responses are routed by ID with no buffering, so every peer must take them.
module mem_arbiter import l1_mem_pkg::*; #(
  parameter int unsigned MemCredits = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Peer channels, indexed by requester ID
  input  logic     [NUM_REQUESTERS-1:0] req_valid_i,
  input  mem_req_t [NUM_REQUESTERS-1:0] req_i,
  output logic     [NUM_REQUESTERS-1:0] gnt_o,
  output logic     [NUM_REQUESTERS-1:0] rsp_valid_o,
  output mem_rsp_t                      rsp_o,
  // Memory bus
  output logic                          mem_req_valid_o,
  output mem_req_t                      mem_req_o,
  input  logic                          credit_i,
  input  logic                          mem_rsp_valid_i,
  input  mem_rsp_t                      mem_rsp_i
);

  localparam int unsigned CntW = $clog2(MemCredits + 1);
  localparam int unsigned PtrW = $clog2(NUM_REQUESTERS);

  typedef logic [CntW-1:0] credit_cnt_t;
  typedef logic [PtrW-1:0] rr_ptr_t;

  rr_ptr_t     rr_ptr_q, rr_ptr_d;   // Highest priority peer
  rr_ptr_t     winner;
  logic        any_valid;
  logic        issue;
  credit_cnt_t credit_cnt_q, credit_cnt_d;

  //////////////////////////////////////////////////////////////////////
  // Round-robin pick
  //////////////////////////////////////////////////////////////////////

  // Walk from the lowest priority up, the last hit is the closest to the pointer
  always_comb begin
    int unsigned idx;
    winner    = rr_ptr_q;
    any_valid = 1'b0;
    for (int unsigned off = NUM_REQUESTERS; off > 0; off--) begin
      idx = (rr_ptr_q + off - 1) % NUM_REQUESTERS;
      if (req_valid_i[idx]) begin
        winner    = rr_ptr_t'(idx);
        any_valid = 1'b1;
      end
    end
  end

  assign issue           = any_valid & (credit_cnt_q != '0);
  assign mem_req_valid_o = issue;
  assign mem_req_o       = req_i[winner];

  assign rr_ptr_d = !issue                          ? rr_ptr_q :
                    (winner == NUM_REQUESTERS - 1)  ? '0       :
                                                      rr_ptr_t'(winner + 1'b1);

  // Grant and response decode per peer
  for (genvar i = 0; i < NUM_REQUESTERS; i++) begin : gen_peer
    assign gnt_o[i]       = issue & (winner == rr_ptr_t'(i));
    assign rsp_valid_o[i] = mem_rsp_valid_i & (mem_rsp_i.id == mem_id_t'(i));
  end

  assign rsp_o = mem_rsp_i;

  //////////////////////////////////////////////////////////////////////
  // Credits
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    credit_cnt_d = credit_cnt_q;
    if (issue && !credit_i) begin
      credit_cnt_d = credit_cnt_q - 1'b1;
    end else if (!issue && credit_i) begin
      credit_cnt_d = credit_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_ptr_q     <= '0;
      credit_cnt_q <= credit_cnt_t'(MemCredits);
    end else begin
      rr_ptr_q     <= rr_ptr_d;
      credit_cnt_q <= credit_cnt_d;
    end
  end

  a_credit_max: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    credit_cnt_q <= MemCredits
  ) else $error("mem_arbiter: credit count %0d above %0d", credit_cnt_q, MemCredits);

  // A credit at full count means the memory freed a slot nobody used
  a_credit_spurious: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    credit_i |-> (credit_cnt_q < MemCredits)
  ) else $error("mem_arbiter: credit returned with no request outstanding");

endmodule : mem_arbiter

/* hdl/miss_port.sv */
`timescale 1ns/1ps
// Holds a single miss; ready stays low until the response for it is back.
// The core must take a response in the cycle it is presented.
// Snoop outputs pulse on each accepted request and are combinational.
module miss_port import l1_mem_pkg::*; #(
  parameter mem_id_t PortId = REQ_ID_FETCH
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Core side
  input  logic     core_req_valid_i,
  input  paddr_t   core_req_addr_i,
  output logic     core_req_ready_o,
  output logic     core_rsp_valid_o,
  output word_t    core_rsp_data_o,
  // Arbiter side
  output logic     arb_req_valid_o,
  output mem_req_t arb_req_o,
  input  logic     arb_gnt_i,
  input  logic     arb_rsp_valid_i,
  input  mem_rsp_t arb_rsp_i,
  // Accepted requests, for the prefetcher
  output logic     snoop_valid_o,
  output paddr_t   snoop_addr_o
);

  typedef enum logic [1:0] {
    MP_IDLE,
    MP_WAIT_GNT,
    MP_WAIT_RSP
  } mp_state_e;

  mp_state_e state_q, state_d;
  paddr_t    addr_q;       // Address of the held miss
  logic      rsp_valid_q;
  word_t     rsp_data_q;
  logic      accept;

  assign core_req_ready_o = (state_q == MP_IDLE);
  assign accept           = core_req_valid_i & core_req_ready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      MP_IDLE: begin
        if (accept) begin
          state_d = MP_WAIT_GNT;
        end
      end
      MP_WAIT_GNT: begin
        if (arb_gnt_i) begin
          state_d = MP_WAIT_RSP;  // Valid drops next cycle
        end
      end
      MP_WAIT_RSP: begin
        if (arb_rsp_valid_i) begin
          state_d = MP_IDLE;
        end
      end
      default: state_d = MP_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= MP_IDLE;
      rsp_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      rsp_valid_q <= arb_rsp_valid_i & (state_q == MP_WAIT_RSP);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= core_req_addr_i;
    end
    if (arb_rsp_valid_i) begin
      rsp_data_q <= arb_rsp_i.data;
    end
  end

  assign arb_req_valid_o  = (state_q == MP_WAIT_GNT);
  assign arb_req_o        = '{id: PortId, addr: addr_q};
  assign core_rsp_valid_o = rsp_valid_q;
  assign core_rsp_data_o  = rsp_data_q;
  assign snoop_valid_o    = accept;
  assign snoop_addr_o     = core_req_addr_i;

  // Routing by ID must only ever hand back our own outstanding miss
  a_rsp_outstanding: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    arb_rsp_valid_i |-> (state_q == MP_WAIT_RSP) && (arb_rsp_i.id == PortId)
  ) else $error("miss_port %0d: response with no miss outstanding", PortId);

endmodule : miss_port

/* tb.f */
hdl/l1_mem_pkg.sv
hdl/miss_port.sv
hdl/hwpf_stride.sv
hdl/mem_arbiter.sv
hdl/l1_miss_subsystem.sv
test/tb_mem_model.sv
test/tb_l1_miss_subsystem.sv

/* test/tb_l1_miss_subsystem.sv */
`timescale 1ns/1ps
// Random fetch and load traffic plus stride load runs, checked by a scoreboard.
// Stops at the first mismatch or timeout. With a single memory credit the two
// competing ports already queue on the credit counter.
module tb_l1_miss_subsystem import l1_mem_pkg::*; ();

  localparam int unsigned MemCredits    = 1;
  localparam int unsigned Seed          = 74;
  localparam int          TimeoutCycles = 2000;
  localparam int          NumTxn        = 40;
  localparam int          NumStride     = 6;
  localparam word_t       DataKey       = 64'h5A3C_96E1_0FF0_C3A5;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        fetch_req_valid;
  paddr_t      fetch_req_addr;
  logic        fetch_req_ready;
  logic        fetch_rsp_valid;
  word_t       fetch_rsp_data;
  logic        load_req_valid;
  paddr_t      load_req_addr;
  logic        load_req_ready;
  logic        load_rsp_valid;
  word_t       load_rsp_data;
  logic        hwpf_enable;
  logic [15:0] hwpf_issued;
  logic        mem_req_valid;
  mem_req_t    mem_req;
  logic        mem_rsp_valid;
  mem_rsp_t    mem_rsp;
  logic        mem_credit;
  int          model_outstanding;
  int          model_hwpf_reqs;

  paddr_t fetch_q[$];   // Accepted and not yet answered
  paddr_t load_q[$];
  paddr_t pf_q[$];      // Prefetch addresses seen on the bus
  int     accepted[2] = '{0, 0};
  int     answered[2] = '{0, 0};
  int     bus_cnt[3]  = '{0, 0, 0};

  always #5 clk = ~clk;

  l1_miss_subsystem #(
    .MemCredits (MemCredits)
  ) l1_miss_subsystem_inst (
    .clk_i (clk), .rst_ni (rst_n),
    .fetch_req_valid_i (fetch_req_valid), .fetch_req_addr_i (fetch_req_addr),
    .fetch_req_ready_o (fetch_req_ready), .fetch_rsp_valid_o (fetch_rsp_valid),
    .fetch_rsp_data_o (fetch_rsp_data),
    .load_req_valid_i (load_req_valid), .load_req_addr_i (load_req_addr),
    .load_req_ready_o (load_req_ready), .load_rsp_valid_o (load_rsp_valid),
    .load_rsp_data_o (load_rsp_data),
    .hwpf_enable_i (hwpf_enable), .hwpf_issued_o (hwpf_issued),
    .mem_req_valid_o (mem_req_valid), .mem_req_o (mem_req),
    .mem_rsp_valid_i (mem_rsp_valid), .mem_rsp_i (mem_rsp), .mem_credit_i (mem_credit)
  );

  tb_mem_model #(
    .DataKey (DataKey)
  ) i_mem (
    .clk_i (clk), .rst_ni (rst_n),
    .mem_req_valid_i (mem_req_valid), .mem_req_i (mem_req),
    .mem_rsp_valid_o (mem_rsp_valid), .mem_rsp_o (mem_rsp), .credit_o (mem_credit),
    .outstanding_o (model_outstanding), .hwpf_reqs_o (model_hwpf_reqs)
  );

  //////////////////////////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      stop_run($sformatf("Fail at %0t ns: %s, got 0x%0h, expected 0x%0h",
                         $time, what, actual, expected));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Scoreboard, sampled on the rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    paddr_t exp_addr;
    if (rst_n) begin
      if (fetch_rsp_valid) begin
        check_value(fetch_q.size(), 1, "fetch misses held at a fetch response");
        exp_addr = fetch_q.pop_front();
        check_value(fetch_rsp_data, {32'h0, exp_addr} ^ DataKey, "fetch response data");
        answered[0]++;
      end
      if (load_rsp_valid) begin
        check_value(load_q.size(), 1, "load misses held at a load response");
        exp_addr = load_q.pop_front();
        check_value(load_rsp_data, {32'h0, exp_addr} ^ DataKey, "load response data");
        answered[1]++;
      end
      if (fetch_req_valid && fetch_req_ready) begin
        fetch_q.push_back(fetch_req_addr);
        accepted[0]++;
      end
      if (load_req_valid && load_req_ready) begin
        load_q.push_back(load_req_addr);
        accepted[1]++;
      end
      if (mem_req_valid) begin
        case (mem_req.id)
          REQ_ID_FETCH: begin
            bus_cnt[0]++;
            check_value(fetch_q.size(), 1, "fetch misses held at a fetch bus request");
            check_value(mem_req.addr, fetch_q[0], "fetch bus request address");
          end
          REQ_ID_LOAD: begin
            bus_cnt[1]++;
            check_value(load_q.size(), 1, "load misses held at a load bus request");
            check_value(mem_req.addr, load_q[0], "load bus request address");
          end
          REQ_ID_HWPF: begin
            bus_cnt[2]++;
            pf_q.push_back(mem_req.addr);
          end
          default: stop_run("A bus request carried an unknown requester ID");
        endcase
      end
    end
  end

  // Peak occupancy is visible here, after capture and before any response
  always @(negedge clk) begin
    if (rst_n) begin
      check_value(model_outstanding <= MemCredits, 1, "bus requests within the credit limit");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  task automatic drive_port(input int port, input logic valid, input paddr_t addr);
    if (port == 0) begin
      fetch_req_valid = valid;
      fetch_req_addr  = addr;
    end else begin
      load_req_valid = valid;
      load_req_addr  = addr;
    end
  endtask

  // Waits for the accept or response counter of a port to reach target
  task automatic await_count(input int port, input bit rsp, input int target);
    int cycles;
    cycles = 0;
    while ((rsp ? answered[port] : accepted[port]) < target) begin
      @(negedge clk);
      cycles++;
      if (cycles > TimeoutCycles) begin
        stop_run($sformatf("Timed out waiting for a %s on port %0d",
                           rsp ? "response" : "request acceptance", port));
      end
    end
  endtask

  // Bus empty and the last response absorbed by the DUT
  task automatic await_idle();
    int cycles;
    cycles = 0;
    while (model_outstanding != 0 || mem_req_valid) begin
      @(negedge clk);
      cycles++;
      if (cycles > TimeoutCycles) begin
        stop_run("Timed out waiting for the memory bus to drain");
      end
    end
    @(negedge clk);
  endtask

  task automatic one_miss(input int port, input paddr_t addr);
    int target;
    target = accepted[port] + 1;
    drive_port(port, 1'b1, addr);
    await_count(port, 1'b0, target);
    drive_port(port, 1'b0, '0);
    await_count(port, 1'b1, target);
  endtask

  task automatic run_port(input int port, input int count);
    for (int i = 0; i < count; i++) begin
      repeat ($urandom_range(3, 0)) @(negedge clk);
      one_miss(port, paddr_t'($urandom) & 32'hFFFF_FFF8);
    end
  endtask

  // Loads one stride apart, each finished before the next
  task automatic run_stride_loads(input paddr_t base, input paddr_t stride, input bit pf_on);
    paddr_t addr;
    int     issued_start;
    issued_start = hwpf_issued;
    for (int k = 0; k < NumStride; k++) begin
      addr = base + stride * k;
      one_miss(1, addr);
      await_idle();
      if (pf_on && k >= 2) begin
        check_value(pf_q.size(), 1, "prefetch requests caused by one load");
        check_value(pf_q.pop_front(), addr + stride, "prefetch address");
      end else begin
        check_value(pf_q.size(), 0, "prefetch requests caused by one load");
      end
      check_value(hwpf_issued, model_hwpf_reqs, "issued prefetch count");
      if (!pf_on) begin
        check_value(hwpf_issued, issued_start, "issued prefetch count while disabled");
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    paddr_t      base;
    paddr_t      stride;
    void'($urandom(Seed));
    fetch_req_valid = 1'b0;
    fetch_req_addr  = '0;
    load_req_valid  = 1'b0;
    load_req_addr   = '0;
    hwpf_enable     = 1'b0;
    rst_n           = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    check_value(fetch_req_ready, 1'b1, "fetch ready after reset");
    check_value(load_req_ready, 1'b1, "load ready after reset");
    check_value(fetch_rsp_valid, 1'b0, "fetch response valid after reset");
    check_value(load_rsp_valid, 1'b0, "load response valid after reset");
    check_value(mem_req_valid, 1'b0, "bus request valid after reset");
    check_value(hwpf_issued, 0, "issued prefetch count after reset");

    // Fetch misses on their own
    run_port(0, NumTxn);
    await_idle();
    check_value(bus_cnt[0], NumTxn, "bus requests with ID 0");
    check_value(bus_cnt[1] + bus_cnt[2], 0, "other bus requests during fetch traffic");

    // Both ports competing
    fork
      run_port(0, NumTxn);
      run_port(1, NumTxn);
    join
    await_idle();
    check_value(bus_cnt[1], NumTxn, "bus requests with ID 1");
    check_value(pf_q.size(), 0, "prefetch requests while disabled");

    base   = paddr_t'($urandom) & 32'hFFFF_F000;
    stride = $urandom_range(8, 1) * 8;
    hwpf_enable = 1'b1;
    run_stride_loads(base, stride, 1'b1);
    hwpf_enable = 1'b0;
    @(negedge clk);
    run_stride_loads(base + 32'h0001_0000, stride, 1'b0);

    $display("All checks passed");
    $finish;
  end

endmodule : tb_l1_miss_subsystem

/* test/tb_mem_model.sv */
`timescale 1ns/1ps
// Memory responder for the miss-path testbench; it never stalls a request.
// Each request is answered after 1 to 8 cycles, one response per cycle at most.
// A credit goes back with every response. Data is the address XOR DataKey.
// Outputs change on the rising edge (capture) and the falling edge (response).
module tb_mem_model import l1_mem_pkg::*; #(
  parameter word_t DataKey = '0
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     mem_req_valid_i,
  input  mem_req_t mem_req_i,
  output logic     mem_rsp_valid_o,
  output mem_rsp_t mem_rsp_o,
  output logic     credit_o,
  output int       outstanding_o,  // Requests minus responses
  output int       hwpf_reqs_o     // Requests seen with the prefetch ID
);

  mem_req_t pend_q[$];
  int       delay_q[$];   // Cycles left per pending request
  int       inflight = 0;
  int       hwpf_cnt = 0;

  initial begin
    int pick;
    mem_rsp_valid_o <= 1'b0;
    mem_rsp_o       <= '0;
    credit_o        <= 1'b0;
    outstanding_o   <= 0;
    hwpf_reqs_o     <= 0;
    forever begin
      @(posedge clk_i);
      if (rst_ni && mem_req_valid_i) begin
        pend_q.push_back(mem_req_i);
        delay_q.push_back($urandom_range(8, 1));
        inflight++;
        if (mem_req_i.id == REQ_ID_HWPF) begin
          hwpf_cnt++;
        end
      end
      outstanding_o <= inflight;
      hwpf_reqs_o   <= hwpf_cnt;

      // Oldest due entry goes first, later ones wait a cycle
      @(negedge clk_i);
      pick = -1;
      for (int i = 0; i < delay_q.size(); i++) begin
        if (delay_q[i] > 0) begin
          delay_q[i]--;
        end
        if (delay_q[i] == 0 && pick < 0) begin
          pick = i;
        end
      end
      mem_rsp_valid_o <= (pick >= 0);
      credit_o        <= (pick >= 0);  // Slot freed with the response
      if (pick >= 0) begin
        mem_rsp_o <= '{id: pend_q[pick].id, data: {32'h0, pend_q[pick].addr} ^ DataKey};
        pend_q.delete(pick);
        delay_q.delete(pick);
        inflight--;
      end
      outstanding_o <= inflight;
    end
  end

endmodule : tb_mem_model
